// ==== source/videogen_pkg.sv ====
`default_nettype none

package videogen_pkg;

	////////////////////
	// Colour channel
	////////////////////

	// One 4-bit gun value per channel
	localparam int COLOR_WIDTH = 4;

	typedef logic [COLOR_WIDTH-1:0] color_t;

	////////////////////
	// Palette word
	////////////////////

	// Three channels packed side by side
	localparam int CLUT_WIDTH = 3 * COLOR_WIDTH;

	// Field positions, red in the bottom nibble
	localparam int RED_LSB = 0;
	localparam int GREEN_LSB = RED_LSB + COLOR_WIDTH;
	localparam int BLUE_LSB = GREEN_LSB + COLOR_WIDTH;

	// Blue on top, then green, then red
	typedef logic [CLUT_WIDTH-1:0] clut_entry_t;

	////////////////////
	// Wishbone slave
	////////////////////

	// Host data bus, upper bits beyond the palette word read as zero
	localparam int WB_DATA_WIDTH = 16;

	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

	// Single-ack handshake
	// WB_IDLE waits for a request
	// WB_ACK holds ack for one clock, then forces a gap
	typedef enum logic {
		WB_IDLE = 1'b0,
		WB_ACK  = 1'b1
	} wb_state_t;

endpackage

`default_nettype wire

// ==== source/clut_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module clut_lookup import videogen_pkg::*; #(
	parameter int INDEX_WIDTH = 8
) (
	input  wire                   clk_6md,
	input  wire                   reset,

	// Pixel side
	input  wire [INDEX_WIDTH-1:0] pixel_index,
	input  wire                   pixel_bank,
	input  wire                   pixel_blank,
	input  wire                   pixel_sync,

	// Wishbone classic slave
	input  wire                   wb_cyc,
	input  wire                   wb_stb,
	input  wire                   wb_we,
	input  wire [INDEX_WIDTH:0]   wb_adr,
	input  wb_data_t              wb_dat_w,
	output wb_data_t              wb_dat_r,
	output logic                  wb_ack,

	// Towards the colour output stage
	output clut_entry_t           palette_word,
	output logic                  stage_blank,
	output logic                  stage_sync
);

	// Bank bit sits above the index
	localparam int ADDR_WIDTH = INDEX_WIDTH + 1;
	localparam int CLUT_DEPTH = 1 << ADDR_WIDTH;

	typedef logic [ADDR_WIDTH-1:0] clut_addr_t;

	////////////////////
	// Palette storage
	////////////////////

	// Two banks of entries loaded by the host
	clut_entry_t clut_ram [CLUT_DEPTH];

	////////////////////
	// Stage one
	////////////////////

	// Latched palette address
	clut_addr_t pixel_addr;

	// Blank and sync after the first stage
	logic       latch_blank;
	logic       latch_sync;

	// Palette address from bank and index
	always_ff @(posedge clk_6md) begin
		pixel_addr <= {pixel_bank, pixel_index};
	end

	// Timing signals follow the index
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			// Blanked with no sync out of reset
			latch_blank <= 1'b1;
			latch_sync  <= 1'b0;
		end else begin
			latch_blank <= pixel_blank;
			latch_sync  <= pixel_sync;
		end
	end

	////////////////////
	// Bus handshake
	////////////////////

	wb_state_t wb_state;
	wb_state_t wb_state_next;

	// Request seen only while no ack is pending
	logic      wb_request;
	logic      wb_write;

	assign wb_request = wb_cyc && wb_stb && (wb_state == WB_IDLE);
	assign wb_write   = wb_request && wb_we;

	// Ack lasts exactly one state
	always_comb begin
		wb_state_next = wb_state;
		case (wb_state)
			WB_IDLE: begin
				if (wb_request) begin
					wb_state_next = WB_ACK;
				end
			end
			WB_ACK: begin
				// Back to idle for a low cycle after each ack
				wb_state_next = WB_IDLE;
			end
			default: begin
				wb_state_next = WB_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_6md) begin
		if (reset) begin
			wb_state <= WB_IDLE;
		end else begin
			wb_state <= wb_state_next;
		end
	end

	// Ack straight from the state register
	assign wb_ack = (wb_state == WB_ACK);

	////////////////////
	// Stage two
	////////////////////

	// Both ports in one process
	// Nonblocking reads return the old word when a write lands on the same entry
	always_ff @(posedge clk_6md) begin
		// Host write keeps the low bits only
		if (wb_write) begin
			clut_ram[wb_adr] <= wb_dat_w[CLUT_WIDTH-1:0];
		end

		// Host read zero-extended to the bus width
		wb_dat_r <= wb_data_t'(clut_ram[wb_adr]);

		// Pixel read port
		palette_word <= clut_ram[pixel_addr];
	end

	// Second delay for blank and sync
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			stage_blank <= 1'b1;
			stage_sync  <= 1'b0;
		end else begin
			// Now in step with palette_word
			stage_blank <= latch_blank;
			stage_sync  <= latch_sync;
		end
	end

endmodule

`default_nettype wire

// ==== source/rgb_output.sv ====
`timescale 1ns/1ps
`default_nettype none

module rgb_output import videogen_pkg::*; (
	input  wire         clk_6md,
	input  wire         reset,

	// From the palette read stage
	input  clut_entry_t palette_word,
	input  wire         stage_blank,
	input  wire         stage_sync,

	// Video out
	output color_t      red,
	output color_t      green,
	output color_t      blue,
	output logic        video_blank,
	output logic        video_sync
);

	////////////////////
	// Channel split
	////////////////////

	// Fields of the palette word
	color_t red_field;
	color_t green_field;
	color_t blue_field;

	assign red_field   = palette_word[RED_LSB +: COLOR_WIDTH];
	assign green_field = palette_word[GREEN_LSB +: COLOR_WIDTH];
	assign blue_field  = palette_word[BLUE_LSB +: COLOR_WIDTH];

	// Black while blanked
	color_t red_next;
	color_t green_next;
	color_t blue_next;

	always_comb begin
		if (stage_blank) begin
			red_next   = '0;
			green_next = '0;
			blue_next  = '0;
		end else begin
			red_next   = red_field;
			green_next = green_field;
			blue_next  = blue_field;
		end
	end

	////////////////////
	// Output register
	////////////////////

	// Third stage of the pixel path
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			// Dark screen, blanked, sync idle
			red         <= '0;
			green       <= '0;
			blue        <= '0;
			video_blank <= 1'b1;
			video_sync  <= 1'b0;
		end else begin
			red         <= red_next;
			green       <= green_next;
			blue        <= blue_next;
			// Last delay for the timing signals
			video_blank <= stage_blank;
			video_sync  <= stage_sync;
		end
	end

endmodule

`default_nettype wire

// ==== source/videogen_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module videogen_subsystem import videogen_pkg::*; #(
	parameter int INDEX_WIDTH = 8
) (
	input  wire                   clk_6md,
	input  wire                   reset,

	// Pixel stream from the beam logic
	input  wire [INDEX_WIDTH-1:0] pixel_index,
	input  wire                   pixel_bank,
	input  wire                   pixel_blank,
	input  wire                   pixel_sync,

	// Host palette port
	input  wire                   wb_cyc,
	input  wire                   wb_stb,
	input  wire                   wb_we,
	input  wire [INDEX_WIDTH:0]   wb_adr,
	input  wb_data_t              wb_dat_w,
	output wb_data_t              wb_dat_r,
	output wire                   wb_ack,

	// Video out, three clocks after the pixel inputs
	output color_t                red,
	output color_t                green,
	output color_t                blue,
	output wire                   video_blank,
	output wire                   video_sync
);

	////////////////////
	// Stage links
	////////////////////

	// Registered palette word and its timing signals
	clut_entry_t palette_word;
	wire         stage_blank;
	wire         stage_sync;

	////////////////////
	// Stages one and two
	////////////////////

	clut_lookup #(
		.INDEX_WIDTH (INDEX_WIDTH)
	) i_clut_lookup (
		.clk_6md      (clk_6md),
		.reset        (reset),
		.pixel_index  (pixel_index),
		.pixel_bank   (pixel_bank),
		.pixel_blank  (pixel_blank),
		.pixel_sync   (pixel_sync),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.palette_word (palette_word),
		.stage_blank  (stage_blank),
		.stage_sync   (stage_sync)
	);

	////////////////////
	// Stage three
	////////////////////

	// Channel split and blanking
	rgb_output i_rgb_output (
		.clk_6md      (clk_6md),
		.reset        (reset),
		.palette_word (palette_word),
		.stage_blank  (stage_blank),
		.stage_sync   (stage_sync),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.video_blank  (video_blank),
		.video_sync   (video_sync)
	);

endmodule

`default_nettype wire

// ==== tb/videogen_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module videogen_assert (
	input wire clk_6md,
	input wire reset,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack
);

	// Number of failed assertions
	int unsigned failures = 0;

	// Ack is a one-clock pulse
	ack_single_cycle: assert property (
		@(posedge clk_6md) disable iff (reset)
		wb_ack |=> !wb_ack
	) else begin
		failures++;
		$error("wb_ack high for two cycles in a row");
	end

	// Request sampled on the edge before every ack
	ack_after_request: assert property (
		@(posedge clk_6md) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb)
	) else begin
		failures++;
		$error("wb_ack without a request on the previous edge");
	end

endmodule

bind clut_lookup videogen_assert i_videogen_assert (
	.clk_6md (clk_6md),
	.reset   (reset),
	.wb_cyc  (wb_cyc),
	.wb_stb  (wb_stb),
	.wb_ack  (wb_ack)
);

`default_nettype wire

// ==== tb/videogen_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module videogen_tb;

	localparam int INDEX_WIDTH = 8;
	localparam int ENTRIES = 1 << (INDEX_WIDTH + 1);
	localparam int CLK_PERIOD = 100;
	localparam int PIXELS = 400;
	// Two cycles per bus transfer for load and readback plus one per pixel driven
	localparam int RUN_CYCLES = ENTRIES * 4 + PIXELS * 4 + 100;

	logic                   clk_6md = 1'b0;
	logic                   reset;
	logic [INDEX_WIDTH-1:0] pixel_index;
	logic                   pixel_bank, pixel_blank, pixel_sync;
	logic                   wb_cyc, wb_stb, wb_we;
	logic [INDEX_WIDTH:0]   wb_adr;
	logic [15:0]            wb_dat_w, wb_dat_r;
	logic                   wb_ack;
	logic [3:0]             red, green, blue;
	logic                   video_blank, video_sync;

	// Reference palette and pipeline state
	logic [11:0]            palette [ENTRIES];
	logic [INDEX_WIDTH:0]   s1_addr;
	logic                   s1_blank, s1_sync;
	logic [11:0]            s2_word;
	logic                   s2_blank, s2_sync;
	logic [3:0]             o_red, o_green, o_blue;
	logic                   o_blank, o_sync;
	logic                   m_ack, m_read;
	logic [15:0]            m_rd_data;

	logic [31:0]            lfsr_state = 32'ha48b_5434;
	logic [31:0]            r;
	int                     checks = 0;
	int                     check_errors = 0;
	int                     bus_errors = 0;
	int                     assert_errors = 0;

	videogen_subsystem #(
		.INDEX_WIDTH (INDEX_WIDTH)
	) i_dut (
		.clk_6md     (clk_6md),
		.reset       (reset),
		.pixel_index (pixel_index),
		.pixel_bank  (pixel_bank),
		.pixel_blank (pixel_blank),
		.pixel_sync  (pixel_sync),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.video_blank (video_blank),
		.video_sync  (video_sync)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk_6md = ~clk_6md;
	end

	////////////////////
	// Random source
	////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	////////////////////
	// Reference model
	////////////////////

	// Inputs change 10 ns after the edge and are stable here
	task automatic model_step();
		logic req;
		if (reset) begin
			o_red   = '0;
			o_green = '0;
			o_blue  = '0;
			o_blank = 1'b1;
			o_sync  = 1'b0;
		end else begin
			o_blank = s2_blank;
			o_sync  = s2_sync;
			// Blue on top, red in the low nibble, black while blanked
			o_red   = s2_blank ? 4'h0 : s2_word[3:0];
			o_green = s2_blank ? 4'h0 : s2_word[7:4];
			o_blue  = s2_blank ? 4'h0 : s2_word[11:8];
		end
		// Pixel read sees the word from before this edge's write
		s2_word  = palette[s1_addr];
		s2_blank = reset | s1_blank;
		s2_sync  = !reset & s1_sync;
		s1_addr  = {pixel_bank, pixel_index};
		s1_blank = reset | pixel_blank;
		s1_sync  = !reset & pixel_sync;
		// One ack per request, then at least one low cycle
		req = wb_cyc && wb_stb && !m_ack;
		if (req) begin
			m_read    = !wb_we;
			m_rd_data = {4'h0, palette[wb_adr]};
			if (wb_we) begin
				palette[wb_adr] = wb_dat_w[11:0];
			end
		end
		m_ack = req && !reset;
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		assert (actual == expected) else begin
			check_errors++;
			$display("[FAIL] %s expected %h got %h at %0t ns", name, expected, actual, $time);
		end
	endtask

	// Compare mid-cycle, including the idle state out of reset
	task automatic check_outputs();
		check_value("red", 16'(o_red), 16'(red));
		check_value("green", 16'(o_green), 16'(green));
		check_value("blue", 16'(o_blue), 16'(blue));
		check_value("video_blank", 16'(o_blank), 16'(video_blank));
		check_value("video_sync", 16'(o_sync), 16'(video_sync));
		check_value("wb_ack", 16'(m_ack), 16'(wb_ack));
		if (m_ack && m_read) begin
			check_value("wb_dat_r", m_rd_data, wb_dat_r);
		end
	endtask

	always @(posedge clk_6md) model_step();
	always @(negedge clk_6md) check_outputs();

	////////////////////
	// Stimulus
	////////////////////

	task automatic drive_pixel(input logic [INDEX_WIDTH:0] addr, input logic blank,
			input logic sync);
		pixel_bank  = addr[INDEX_WIDTH];
		pixel_index = addr[INDEX_WIDTH-1:0];
		pixel_blank = blank;
		pixel_sync  = sync;
		@(posedge clk_6md);
		#10;
	endtask

	task automatic start_transfer(input logic we, input logic [INDEX_WIDTH:0] adr,
			input logic [15:0] data);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = data;
	endtask

	task automatic end_transfer();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	// Hold stb until the ack shows up
	task automatic bus_transfer(input logic we, input logic [INDEX_WIDTH:0] adr,
			input logic [15:0] data);
		int waited;
		waited = 0;
		start_transfer(we, adr, data);
		do begin
			@(posedge clk_6md);
			#10;
			waited++;
		end while (!wb_ack && waited < 4);
		assert (wb_ack) else begin
			bus_errors++;
			$display("No ack for the bus transfer to address %h", adr);
		end
		end_transfer();
	endtask

	task automatic run_pixels(input int count, input logic timing);
		for (int i = 0; i < count; i++) begin
			r = rand_bits(INDEX_WIDTH + 3);
			drive_pixel(r[INDEX_WIDTH:0], timing & r[INDEX_WIDTH+1], timing & r[INDEX_WIDTH+2]);
		end
	endtask

	// Writes during active video with the address held a few pixels at a time
	task automatic run_live_writes(input int count);
		logic [INDEX_WIDTH:0] addr;
		int wait_cycles;
		addr = '0;
		wait_cycles = 0;
		for (int i = 0; i < count; i++) begin
			if (wb_stb && wb_ack) begin
				end_transfer();
			end else if (wb_stb) begin
				wait_cycles++;
				assert (wait_cycles != 4) else begin
					bus_errors++;
					$display("Write to address %h during video got no ack", wb_adr);
				end
			end else begin
				r = rand_bits(2);
				if (r[1:0] == 2'b00) begin
					// Lands on the edge that reads the last pixel's entry
					r = rand_bits(16);
					start_transfer(1'b1, addr, r[15:0]);
					wait_cycles = 0;
				end
			end
			r = rand_bits(2);
			if (r[1:0] == 2'b00) begin
				r = rand_bits(INDEX_WIDTH + 1);
				addr = r[INDEX_WIDTH:0];
			end
			drive_pixel(addr, 1'b0, 1'b0);
		end
		if (wb_stb && !wb_ack) begin
			@(posedge clk_6md);
			#10;
		end
		end_transfer();
	endtask

	initial begin
		reset       = 1'b1;
		pixel_index = '0;
		pixel_bank  = 1'b0;
		pixel_blank = 1'b1;
		pixel_sync  = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		repeat (8) @(posedge clk_6md);
		#10;
		reset = 1'b0;
		// Idle cycles out of reset are checked by the model as well
		drive_pixel('0, 1'b1, 1'b0);
		// Full palette load with junk in the upper bits and a readback
		for (int a = 0; a < ENTRIES; a++) begin
			r = rand_bits(16);
			bus_transfer(1'b1, a[INDEX_WIDTH:0], r[15:0]);
		end
		for (int a = 0; a < ENTRIES; a++) begin
			bus_transfer(1'b0, a[INDEX_WIDTH:0], 16'h0);
		end
		// Same index from both banks
		r = rand_bits(INDEX_WIDTH);
		drive_pixel({1'b0, r[INDEX_WIDTH-1:0]}, 1'b0, 1'b0);
		drive_pixel({1'b1, r[INDEX_WIDTH-1:0]}, 1'b0, 1'b0);
		run_pixels(PIXELS, 1'b0);
		run_pixels(PIXELS, 1'b1);
		run_live_writes(2 * PIXELS);
		// Flush the pipeline
		repeat (4) drive_pixel('0, 1'b1, 1'b0);
		// Failures of the bound bus checker
		assert_errors = i_dut.i_clut_lookup.i_videogen_assert.failures;
		$display("Checks: %0d, output errors: %0d, bus errors: %0d, assertion errors: %0d",
			checks, check_errors, bus_errors, assert_errors);
		if (check_errors + bus_errors + assert_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, the stimulus never finished", RUN_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
source/videogen_pkg.sv
source/clut_lookup.sv
source/rgb_output.sv
source/videogen_subsystem.sv
tb/videogen_assert.sv
tb/videogen_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= videogen_tb
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
MDIR      ?= obj_dir

SOURCES := $(shell grep -v '^+' tb.f)
BIN     := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when the file list or a source changes
$(BIN): tb.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f tb.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(MDIR)
